// File: src/pwrPkg.sv
// Shared types and constants for the power shutoff controller
// Sequencer states, host register map and the domain control bundle
// Every RTL file refers to these through scoped pwrPkg:: names
package pwrPkg;

  // ------------------------------
  // Sizes and timing
  // ------------------------------

  // Width of the domain activity counter and of the retained word
  localparam int unsigned domainWidth = 8;

  // Stabilisation counter width
  localparam int unsigned stableCntWidth = 5;
  // Cycles spent in stPwrOn2 before the restore pulse
  localparam logic [stableCntWidth-1:0] stableCycles = 5'd28;

  // ------------------------------
  // Sequencer states
  // ------------------------------
  typedef enum logic [3:0] {
    stInit,
    stClkOff,
    stWait1,
    stIsolate,
    stSaveEdge,
    stPrePwrOff,
    stPwrOff,
    stPwrOn1,
    stPwrOn2,
    stRestoreEdge,
    stWait2,
    stDeIsolate,
    stClkOn,
    stWait3,
    stRstClr
  } pwrState;

  // Host register map, one bit per register
  typedef enum logic [0:0] {
    addrCtrl   = 1'b0,
    addrStatus = 1'b1
  } regAddr;

  // Domain control bundle, all fields active as named
  typedef struct packed {
    logic gateClk;
    logic isolate;
    logic rstnNonSrpg;
    logic saveEdge;
    logic restoreEdge;
    logic pwr1On;
    logic pwr2On;
  } pwrCtrl;

endpackage

// File: src/pwrRegs.sv
// Host side control and status registers for the shutoff controller
// Host writes the shutdown request bit, the sequencer sets and clears status
// Read data is a plain combinational mux on the read address
`timescale 1ns/1ps

module pwrRegs (
  input  logic           pclk11,
  input  logic           nprst11,
  input  logic           wrEn,
  input  pwrPkg::regAddr wrAddr,
  input  logic           wrData,
  input  pwrPkg::regAddr rdAddr,
  output logic           rdData,
  input  logic           setStatus,
  input  logic           clrStatus,
  output logic           l1Req
);

  // Domain off status, owned by the sequencer
  logic statusOff;

  // Shutdown request bit
  // Only a write to addrCtrl reaches it
  always_ff @(posedge pclk11 or negedge nprst11)
  begin
    if (!nprst11)
      l1Req <= 1'b0;
    else if (wrEn && (wrAddr == pwrPkg::addrCtrl))
      l1Req <= wrData;
  end

  // Status bit
  // Host writes to addrStatus are ignored, read only from the host side
  // Set and clear never coincide, set is checked first anyway
  always_ff @(posedge pclk11 or negedge nprst11)
  begin
    if (!nprst11)
      statusOff <= 1'b0;
    else if (setStatus)
      statusOff <= 1'b1;
    else if (clrStatus)
      statusOff <= 1'b0;
  end

  // Read mux
  always_comb
  begin
    case (rdAddr)
      pwrPkg::addrCtrl:   rdData = l1Req;
      pwrPkg::addrStatus: rdData = statusOff;
      default:            rdData = 1'b0;
    endcase
  end

endmodule

// File: src/pwrSeq.sv
// Power shutoff sequencer for one switchable domain
// Walks clock gating, isolation, save, power off, power on, restore and release
// Control outputs are registered from the next state so each one moves
// at the edge that enters its state
`timescale 1ns/1ps

module pwrSeq (
  input  logic           pclk11,
  input  logic           nprst11,
  input  logic           l1Req,
  output logic           setStatus,
  output logic           clrStatus,
  output pwrPkg::pwrCtrl domCtrl
);

  pwrPkg::pwrState currentState;
  pwrPkg::pwrState nextState;

  // Stabilisation count while in stPwrOn2
  logic [pwrPkg::stableCntWidth-1:0] stableCnt;

  // Registered control levels
  logic gateClkQ;
  logic isolateQ;
  logic rstnQ;
  logic saveQ;
  logic restoreQ;
  logic pwr1Q;
  logic pwr2Q;

  // ------------------------------
  // Next-state decode
  // ------------------------------
  always_comb
  begin
    case (currentState)
      // Start shutoff once the host raises the request
      pwrPkg::stInit:
        nextState = l1Req ? pwrPkg::stClkOff : pwrPkg::stInit;
      pwrPkg::stClkOff:      nextState = pwrPkg::stWait1;
      // One cycle for the clock gate to settle
      pwrPkg::stWait1:       nextState = pwrPkg::stIsolate;
      pwrPkg::stIsolate:     nextState = pwrPkg::stSaveEdge;
      pwrPkg::stSaveEdge:    nextState = pwrPkg::stPrePwrOff;
      pwrPkg::stPrePwrOff:   nextState = pwrPkg::stPwrOff;
      // Held off until the host drops the request
      pwrPkg::stPwrOff:
        nextState = l1Req ? pwrPkg::stPwrOff : pwrPkg::stPwrOn1;
      pwrPkg::stPwrOn1:      nextState = pwrPkg::stPwrOn2;
      // Supply settles for stableCycles cycles
      pwrPkg::stPwrOn2:
        nextState = (stableCnt == pwrPkg::stableCycles) ? pwrPkg::stRestoreEdge
                                                        : pwrPkg::stPwrOn2;
      pwrPkg::stRestoreEdge: nextState = pwrPkg::stWait2;
      pwrPkg::stWait2:       nextState = pwrPkg::stDeIsolate;
      pwrPkg::stDeIsolate:   nextState = pwrPkg::stClkOn;
      pwrPkg::stClkOn:       nextState = pwrPkg::stWait3;
      // Clock runs again before the reset is released
      pwrPkg::stWait3:       nextState = pwrPkg::stRstClr;
      pwrPkg::stRstClr:      nextState = pwrPkg::stInit;
      default:               nextState = pwrPkg::stInit;
    endcase
  end

  always_ff @(posedge pclk11 or negedge nprst11)
  begin
    if (!nprst11)
      currentState <= pwrPkg::stInit;
    else
      currentState <= nextState;
  end

  // ------------------------------
  // Registered domain controls
  // ------------------------------

  // Clock removed from stClkOff up to stDeIsolate
  always_ff @(posedge pclk11 or negedge nprst11)
  begin
    if (!nprst11)
      gateClkQ <= 1'b0;
    else
      gateClkQ <= !(nextState inside {pwrPkg::stClkOn, pwrPkg::stWait3,
                                      pwrPkg::stRstClr, pwrPkg::stInit});
  end

  // Outputs clamped from stIsolate through stWait2
  always_ff @(posedge pclk11 or negedge nprst11)
  begin
    if (!nprst11)
      isolateQ <= 1'b0;
    else
      isolateQ <= nextState inside {pwrPkg::stIsolate, pwrPkg::stSaveEdge,
                                    pwrPkg::stPrePwrOff, pwrPkg::stPwrOff,
                                    pwrPkg::stPwrOn1, pwrPkg::stPwrOn2,
                                    pwrPkg::stRestoreEdge, pwrPkg::stWait2};
  end

  // Non-retained reset held from power off until stRstClr
  always_ff @(posedge pclk11 or negedge nprst11)
  begin
    if (!nprst11)
      rstnQ <= 1'b0;
    else
      rstnQ <= nextState inside {pwrPkg::stInit, pwrPkg::stClkOff, pwrPkg::stWait1,
                                 pwrPkg::stIsolate, pwrPkg::stSaveEdge,
                                 pwrPkg::stPrePwrOff, pwrPkg::stRstClr};
  end

  // Single cycle save and restore pulses
  always_ff @(posedge pclk11 or negedge nprst11)
  begin
    if (!nprst11)
    begin
      saveQ    <= 1'b0;
      restoreQ <= 1'b0;
    end
    else
    begin
      saveQ    <= (nextState == pwrPkg::stSaveEdge);
      restoreQ <= (nextState == pwrPkg::stRestoreEdge);
    end
  end

  // Both switches closed out of reset
  // Switch 1 opens only in stPwrOff, switch 2 closes one state later
  always_ff @(posedge pclk11 or negedge nprst11)
  begin
    if (!nprst11)
    begin
      pwr1Q <= 1'b1;
      pwr2Q <= 1'b1;
    end
    else
    begin
      pwr1Q <= (nextState != pwrPkg::stPwrOff);
      pwr2Q <= !(nextState inside {pwrPkg::stPwrOff, pwrPkg::stPwrOn1});
    end
  end

  // Counts while stPwrOn2 is current or about to be entered
  always_ff @(posedge pclk11 or negedge nprst11)
  begin
    if (!nprst11)
      stableCnt <= '0;
    else if (nextState == pwrPkg::stPwrOn2)
      stableCnt <= stableCnt + 1'b1;
    else
      stableCnt <= '0;
  end

  // ------------------------------
  // Outputs
  // ------------------------------
  assign domCtrl.gateClk     = gateClkQ;
  assign domCtrl.isolate     = isolateQ;
  // Domain reset from either the power sequence or the system reset
  assign domCtrl.rstnNonSrpg = rstnQ & nprst11;
  assign domCtrl.saveEdge    = saveQ;
  assign domCtrl.restoreEdge = restoreQ;
  assign domCtrl.pwr1On      = pwr1Q;
  assign domCtrl.pwr2On      = pwr2Q;

  // Status strobes
  assign setStatus = (nextState == pwrPkg::stClkOff);
  assign clrStatus = (currentState == pwrPkg::stRstClr);

endmodule

// File: src/retentionStore.sv
// Always-on retention bank for the switchable domain
// Captures the live domain word on the save pulse and keeps it through power off
// The held word feeds the domain's restore load
`timescale 1ns/1ps

module retentionStore (
  input  logic                             pclk11,
  input  logic                             nprst11,
  input  pwrPkg::pwrCtrl                   domCtrl,
  input  logic [pwrPkg::domainWidth-1:0]   domState,
  output logic [pwrPkg::domainWidth-1:0]   savedState
);

  // Held word
  logic [pwrPkg::domainWidth-1:0] heldWord;

  // ------------------------------
  // Capture
  // ------------------------------

  // Sits on the always-on supply
  // Only the system reset clears it, never the domain reset
  always_ff @(posedge pclk11 or negedge nprst11)
  begin
    if (!nprst11)
      heldWord <= '0;
    else if (domCtrl.saveEdge)
      heldWord <= domState;
  end

  // Valid from the cycle after the save pulse
  assign savedState = heldWord;

endmodule

// File: src/gatedDomain.sv
// Switchable logic domain modelled as an activity counter
// Counts actEn while its clock runs, loses state when power is removed,
// reloads from the retention bank on restore and clamps outputs when isolated
`timescale 1ns/1ps

module gatedDomain (
  input  logic                             pclk11,
  input  logic                             nprst11,
  input  pwrPkg::pwrCtrl                   domCtrl,
  input  logic                             actEn,
  input  logic [pwrPkg::domainWidth-1:0]   savedState,
  output logic [pwrPkg::domainWidth-1:0]   domState,
  output logic [pwrPkg::domainWidth-1:0]   domainCount
);

  logic [pwrPkg::domainWidth-1:0] actCnt;

  // Local clock enable, low while the sequencer gates the clock
  logic clkEn;
  // Domain held in reset with its supply not yet back
  logic powerLost;

  assign clkEn     = !domCtrl.gateClk;
  assign powerLost = !domCtrl.rstnNonSrpg && !domCtrl.pwr2On;

  // ------------------------------
  // Activity counter
  // ------------------------------

  // Contents vanish while power is off
  // Restore reload comes once both switches are closed again
  always_ff @(posedge pclk11 or negedge nprst11)
  begin
    if (!nprst11)
      actCnt <= '0;
    else if (powerLost)
      actCnt <= '0;
    else if (domCtrl.restoreEdge)
      actCnt <= savedState;
    else if (clkEn && actEn)
      actCnt <= actCnt + 1'b1;
  end

  // Live value for the retention bank
  assign domState = actCnt;

  // Isolation clamp to zero
  assign domainCount = domCtrl.isolate ? '0 : actCnt;

endmodule

// File: src/pwrCtrlTop.sv
// Power shutoff controller top level
// Host registers drive the sequencer, which controls the switchable domain
// and its retention bank, the domain controls are exported for observation
`timescale 1ns/1ps

module pwrCtrlTop (
  input  logic                             pclk11,
  input  logic                             nprst11,
  input  logic                             wrEn,
  input  pwrPkg::regAddr                   wrAddr,
  input  logic                             wrData,
  input  pwrPkg::regAddr                   rdAddr,
  output logic                             rdData,
  input  logic                             actEn,
  output pwrPkg::pwrCtrl                   domCtrl,
  output logic [pwrPkg::domainWidth-1:0]   domainCount
);

  // Register block to sequencer
  logic l1Req;
  logic setStatus;
  logic clrStatus;

  // Domain and retention bank
  logic [pwrPkg::domainWidth-1:0] domState;
  logic [pwrPkg::domainWidth-1:0] savedState;

  pwrRegs uRegs (
    .pclk11    (pclk11),
    .nprst11   (nprst11),
    .wrEn      (wrEn),
    .wrAddr    (wrAddr),
    .wrData    (wrData),
    .rdAddr    (rdAddr),
    .rdData    (rdData),
    .setStatus (setStatus),
    .clrStatus (clrStatus),
    .l1Req     (l1Req)
  );

  pwrSeq uSeq (
    .pclk11    (pclk11),
    .nprst11   (nprst11),
    .l1Req     (l1Req),
    .setStatus (setStatus),
    .clrStatus (clrStatus),
    .domCtrl   (domCtrl)
  );

  retentionStore uStore (
    .pclk11     (pclk11),
    .nprst11    (nprst11),
    .domCtrl    (domCtrl),
    .domState   (domState),
    .savedState (savedState)
  );

  gatedDomain uDomain (
    .pclk11      (pclk11),
    .nprst11     (nprst11),
    .domCtrl     (domCtrl),
    .actEn       (actEn),
    .savedState  (savedState),
    .domState    (domState),
    .domainCount (domainCount)
  );

endmodule

// File: tb/pwrSeq_properties.sv
// Concurrent checks on the shutoff sequencer outputs
// Bound into pwrSeq from the testbench, reports only through assertion failures
`timescale 1ns/1ps

module pwrSeqProperties (
  input logic           pclk11,
  input logic           nprst11,
  input logic           setStatus,
  input logic           clrStatus,
  input pwrPkg::pwrCtrl domCtrl
);

  // Status strobes never overlap
  strobeExclusive: assert property (@(posedge pclk11) disable iff (!nprst11)
    !(setStatus && clrStatus))
    else $error("Status set and clear strobes are high in the same cycle");

  // Isolation follows the clock gate by two cycles
  isoAfterGate: assert property (@(posedge pclk11) disable iff (!nprst11)
    $rose(domCtrl.gateClk) |-> ##2 $rose(domCtrl.isolate))
    else $error("Isolation did not rise two cycles after clock gating");

  // Second switch never closed while the first is open
  switchOrder: assert property (@(posedge pclk11) disable iff (!nprst11)
    !domCtrl.pwr1On |-> !domCtrl.pwr2On)
    else $error("Second power switch closed while the first one is open");

  // Save and restore are single cycle pulses
  savePulse: assert property (@(posedge pclk11) disable iff (!nprst11)
    $rose(domCtrl.saveEdge) |=> !domCtrl.saveEdge)
    else $error("Save pulse lasted longer than one cycle");

  restorePulse: assert property (@(posedge pclk11) disable iff (!nprst11)
    $rose(domCtrl.restoreEdge) |=> !domCtrl.restoreEdge)
    else $error("Restore pulse lasted longer than one cycle");

endmodule

// File: tb/pwrCtrlTb.sv
// Testbench for the power shutoff controller
// Runs seeded shutdown cycles with random domain activity and host status writes
// Tracks the domain counter, its retained copy and the status bit in a model
// and checks the sequencer timing around every entry and exit
`timescale 1ns/1ps

module pwrCtrlTb;

  logic                           pclk11;
  logic                           nprst11;
  logic                           wrEn;
  pwrPkg::regAddr                 wrAddr;
  logic                           wrData;
  pwrPkg::regAddr                 rdAddr;
  logic                           rdData;
  logic                           actEn;
  pwrPkg::pwrCtrl                 domCtrl;
  logic [pwrPkg::domainWidth-1:0] domainCount;

  int checkErrors;
  int timeoutErrors;
  bit abortRun;

  // Reference model state
  logic [pwrPkg::domainWidth-1:0] expCnt;
  logic [pwrPkg::domainWidth-1:0] expSaved;
  logic                           expStatus;
  logic                           clearPending;
  logic                           prevGate;
  logic                           prevRstn;

  pwrCtrlTop DUT (
    .pclk11      (pclk11),
    .nprst11     (nprst11),
    .wrEn        (wrEn),
    .wrAddr      (wrAddr),
    .wrData      (wrData),
    .rdAddr      (rdAddr),
    .rdData      (rdData),
    .actEn       (actEn),
    .domCtrl     (domCtrl),
    .domainCount (domainCount)
  );

  bind pwrSeq pwrSeqProperties uSeqProps (
    .pclk11    (pclk11),
    .nprst11   (nprst11),
    .setStatus (setStatus),
    .clrStatus (clrStatus),
    .domCtrl   (domCtrl)
  );

  // 10 ns clock
  always
  begin
    #5 pclk11 = ~pclk11;
  end

  // Random domain activity, one new value per cycle
  always @(posedge pclk11)
  begin
    #1;
    actEn = $urandom % 2;
  end

  task automatic checkVal(input string name, input int expVal, input int actVal);
    if (expVal != actVal)
    begin
      checkErrors++;
      $display("error %s: expected %0d, actual %0d at %0t", name, expVal, actVal, $time);
    end
  endtask

  task automatic timeoutHit(input string what);
    timeoutErrors++;
    abortRun = 1'b1;
    $display("Timeout: the DUT never reached %s at %0t", what, $time);
  endtask

  function automatic pwrPkg::pwrCtrl makeCtrl(input logic gate, input logic iso,
                                              input logic rstn, input logic save,
                                              input logic restore, input logic p1,
                                              input logic p2);
    pwrPkg::pwrCtrl c;
    c.gateClk     = gate;
    c.isolate     = iso;
    c.rstnNonSrpg = rstn;
    c.saveEdge    = save;
    c.restoreEdge = restore;
    c.pwr1On      = p1;
    c.pwr2On      = p2;
    return c;
  endfunction

  // Field by field compare of the domain controls
  task automatic checkCtrl(input string name, input pwrPkg::pwrCtrl expCtrl);
    checkVal({name, " gateClk"}, expCtrl.gateClk, domCtrl.gateClk);
    checkVal({name, " isolate"}, expCtrl.isolate, domCtrl.isolate);
    checkVal({name, " rstnNonSrpg"}, expCtrl.rstnNonSrpg, domCtrl.rstnNonSrpg);
    checkVal({name, " saveEdge"}, expCtrl.saveEdge, domCtrl.saveEdge);
    checkVal({name, " restoreEdge"}, expCtrl.restoreEdge, domCtrl.restoreEdge);
    checkVal({name, " pwr1On"}, expCtrl.pwr1On, domCtrl.pwr1On);
    checkVal({name, " pwr2On"}, expCtrl.pwr2On, domCtrl.pwr2On);
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------

  // Sampled at the falling edge, where both DUT outputs and driven inputs are settled
  always @(negedge pclk11)
  begin
    if (nprst11 !== 1'b1)
    begin
      expCnt       = '0;
      expSaved     = '0;
      expStatus    = 1'b0;
      clearPending = 1'b0;
      prevGate     = 1'b0;
      prevRstn     = 1'b0;
    end
    else
    begin
      // Status follows the sequence, set with the clock gate and
      // cleared one cycle after the domain reset lifts
      if (clearPending)
      begin
        expStatus    = 1'b0;
        clearPending = 1'b0;
      end
      if (domCtrl.gateClk && !prevGate)
        expStatus = 1'b1;
      checkVal("domain count", domCtrl.isolate ? 0 : expCnt, domainCount);
      if (rdAddr == pwrPkg::addrStatus)
        checkVal("status bit", expStatus, rdData);
      if (domCtrl.rstnNonSrpg && !prevRstn && expStatus)
        clearPending = 1'b1;
      // Retention bank captures the live count on the save pulse
      if (domCtrl.saveEdge)
        expSaved = expCnt;
      // Counter value after the coming edge
      if (!domCtrl.rstnNonSrpg && !domCtrl.pwr2On)
        expCnt = '0;
      else if (domCtrl.restoreEdge)
        expCnt = expSaved;
      else if (!domCtrl.gateClk && actEn)
        expCnt = expCnt + 1'b1;
      prevGate = domCtrl.gateClk;
      prevRstn = domCtrl.rstnNonSrpg;
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  // Single cycle host write strobe
  task automatic hostWrite(input pwrPkg::regAddr addr, input logic data);
    @(posedge pclk11);
    #1;
    wrEn   = 1'b1;
    wrAddr = addr;
    wrData = data;
    @(posedge pclk11);
    #1;
    wrEn = 1'b0;
  endtask

  // One cycle with an occasional write to the read-only status register
  task automatic idleCycle();
    @(posedge pclk11);
    #1;
    wrEn   = ($urandom % 4) == 0;
    wrAddr = pwrPkg::addrStatus;
    wrData = $urandom % 2;
    @(negedge pclk11);
  endtask

  task automatic idlePhase();
    int idleLen;
    idleLen = 2 + ($urandom % 7);
    for (int i = 0; i < idleLen; i++)
    begin
      idleCycle();
      checkVal("no shutdown from status writes", 0, domCtrl.gateClk);
    end
  endtask

  // Full entry, dwell and exit with offsets taken from the gateClk and pwr1On rises
  task automatic runShutdown();
    bit found;
    int dwell;
    int waitCnt;
    dwell = 1 + ($urandom % 20);
    found = 1'b0;
    hostWrite(pwrPkg::addrCtrl, 1'b1);
    for (int k = 0; k < 10 && !found; k++)
    begin
      @(negedge pclk11);
      found = domCtrl.gateClk;
    end
    if (!found)
    begin
      timeoutHit("clock gating after the request");
      return;
    end
    for (int k = 0; k <= 5; k++)
    begin
      if (k > 0)
        @(negedge pclk11);
      checkCtrl("entry", makeCtrl(1'b1, k >= 2, k < 5, k == 3, 1'b0, k < 5, k < 5));
    end
    // Request held high keeps the domain off
    for (int d = 0; d < dwell; d++)
    begin
      idleCycle();
      checkVal("power held off", 0, domCtrl.pwr1On);
    end
    hostWrite(pwrPkg::addrCtrl, 1'b0);
    found = 1'b0;
    for (int k = 0; k < 10 && !found; k++)
    begin
      @(negedge pclk11);
      found = domCtrl.pwr1On;
    end
    if (!found)
    begin
      timeoutHit("power on after the request was cleared");
      return;
    end
    checkVal("pwr2On with pwr1On", 0, domCtrl.pwr2On);
    found   = 1'b0;
    waitCnt = 0;
    while (!found && waitCnt < 60)
    begin
      @(negedge pclk11);
      waitCnt++;
      if (waitCnt == 1)
        checkVal("pwr2On one cycle later", 1, domCtrl.pwr2On);
      found = domCtrl.restoreEdge;
    end
    if (!found)
    begin
      timeoutHit("the restore pulse");
      return;
    end
    checkVal("restore offset", pwrPkg::stableCycles + 1, waitCnt);
    for (int k = 0; k <= 6; k++)
    begin
      if (k > 0)
        @(negedge pclk11);
      checkCtrl("exit", makeCtrl(k < 3, k < 2, k >= 5, 1'b0, k == 0, 1'b1, 1'b1));
      // First cycle out of isolation shows the word the model saved
      if (k == 2)
        checkVal("retained count", expSaved, domainCount);
    end
  endtask

  initial
  begin
    void'($urandom(32'h26c2));
    checkErrors   = 0;
    timeoutErrors = 0;
    abortRun      = 1'b0;
    pclk11        = 1'b0;
    nprst11       = 1'b0;
    wrEn          = 1'b0;
    wrAddr        = pwrPkg::addrCtrl;
    wrData        = 1'b0;
    rdAddr        = pwrPkg::addrCtrl;
    actEn         = 1'b0;
    // Reset levels, both registers read while reset is held
    @(negedge pclk11);
    checkCtrl("reset", makeCtrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1));
    checkVal("reset ctrl read", 0, rdData);
    checkVal("reset count", 0, domainCount);
    @(posedge pclk11);
    #1;
    rdAddr = pwrPkg::addrStatus;
    @(negedge pclk11);
    checkVal("reset status read", 0, rdData);
    @(posedge pclk11);
    #1;
    nprst11 = 1'b1;
    // Domain reset lifts at the first edge after release
    @(negedge pclk11);
    @(negedge pclk11);
    checkCtrl("after reset", makeCtrl(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1));
    for (int n = 0; n < 8 && !abortRun; n++)
    begin
      idlePhase();
      runShutdown();
    end
    $display("Checks failed: %0d, timeouts: %0d", checkErrors, timeoutErrors);
    if (checkErrors == 0 && timeoutErrors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: list.f
src/pwrPkg.sv
src/pwrRegs.sv
src/pwrSeq.sv
src/retentionStore.sv
src/gatedDomain.sv
src/pwrCtrlTop.sv
tb/pwrSeq_properties.sv
tb/pwrCtrlTb.sv
